// ==== hw/integer_alu_pkg.sv ====
`default_nettype none

package integer_alu_pkg;

    // Datapath width, tied to the IEEE single format
    localparam int WORD_W = 32;

    // IEEE single precision fields
    localparam int FP_EXP_W = 8;
    localparam int FP_MAN_W = 23;
    localparam int FP_BIAS  = 127;

    //////////////////////////////////////////////////
    // Opcodes
    // 00xx arithmetic, 01xx logic, 1x0x halfword writes, 1x1x conversions
    typedef enum logic [3:0] {
        OP_ADD        = 4'b0000,
        OP_SUB        = 4'b0001,
        OP_MUL        = 4'b0010,
        OP_DIV        = 4'b0011,
        OP_NOT        = 4'b0100,
        OP_AND        = 4'b0101,
        OP_OR         = 4'b0110,
        OP_XOR        = 4'b0111,
        OP_WRITE_HIGH = 4'b1000,
        OP_WRITE_LOW  = 4'b1001,
        OP_ITOF       = 4'b1010,
        OP_FTOI       = 4'b1011
    } alu_op_e;

    // Low two opcode bits of the arithmetic group
    typedef enum logic [1:0] {
        ARITH_ADD = 2'b00,
        ARITH_SUB = 2'b01,
        ARITH_MUL = 2'b10,
        ARITH_DIV = 2'b11
    } arith_op_e;

    //////////////////////////////////////////////////
    // Request and response
    typedef struct packed {
        alu_op_e           opcode;
        logic [WORD_W-1:0] op1;
        logic [WORD_W-1:0] op2;
    } alu_req_t;

    // flag[0] result is zero, flag[1] overflow
    typedef struct packed {
        logic [WORD_W-1:0] out;
        logic [1:0]        flag;
    } alu_rsp_t;

    //////////////////////////////////////////////////
    // FSM states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOCAL,
        CTRL_WAIT_UNIT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        ARITH_IDLE,
        ARITH_ITER,
        ARITH_FINISH
    } arith_state_e;

endpackage

`default_nettype wire

// ==== hw/alu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_ctrl
    import integer_alu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  alu_req_t          req,
    output alu_rsp_t          rsp,
    output logic              done,
    output logic              busy,
    output logic              arith_start,
    output arith_op_e         arith_op,
    output logic [WORD_W-1:0] arith_a,
    output logic [WORD_W-1:0] arith_b,
    input  logic [WORD_W-1:0] arith_result,
    input  logic [1:0]        arith_flag,
    input  logic              arith_done,
    output logic              itof_start,
    input  logic [WORD_W-1:0] itof_result,
    input  logic              itof_done,
    output logic              ftoi_start,
    input  logic [WORD_W-1:0] ftoi_result,
    input  logic              ftoi_done,
    output logic [WORD_W-1:0] cvt_in
);

    localparam int HALF_W = WORD_W / 2;

    ctrl_state_e       state;
    alu_op_e           dec_op;
    alu_op_e           op_q;
    logic              accept;
    logic              is_arith;
    logic              is_local;
    logic              unit_done;
    logic [WORD_W-1:0] local_out;

    // Bit 3 picks the special group, bit 2 only matters below it,
    // so 11xx folds onto 10xx
    assign dec_op = alu_op_e'({req.opcode[3],
                               req.opcode[2] & ~req.opcode[3],
                               req.opcode[1:0]});

    assign accept    = en && (state == CTRL_IDLE);
    assign is_arith  = dec_op inside {OP_ADD, OP_SUB, OP_MUL, OP_DIV};
    assign is_local  = !is_arith && !(dec_op inside {OP_ITOF, OP_FTOI});
    assign unit_done = arith_done || itof_done || ftoi_done;
    assign busy      = (state != CTRL_IDLE);

    // Units capture their operands on the start edge
    assign arith_start = accept && is_arith;
    assign itof_start  = accept && (dec_op == OP_ITOF);
    assign ftoi_start  = accept && (dec_op == OP_FTOI);
    assign arith_op    = arith_op_e'(dec_op[1:0]);
    assign arith_a     = req.op1;
    assign arith_b     = req.op2;
    assign cvt_in      = req.op1;

    //////////////////////////////////////////////////
    // Logic and halfword results
    always_comb begin
        case (dec_op)
            OP_NOT:        local_out = ~req.op1;
            OP_AND:        local_out = req.op1 & req.op2;
            OP_OR:         local_out = req.op1 | req.op2;
            OP_XOR:        local_out = req.op1 ^ req.op2;
            OP_WRITE_HIGH: local_out = {req.op2[HALF_W-1:0], req.op1[HALF_W-1:0]};
            OP_WRITE_LOW:  local_out = {req.op1[WORD_W-1:HALF_W], req.op2[HALF_W-1:0]};
            default:       local_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Control FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                CTRL_IDLE: begin
                    if (en) begin
                        if (is_local) begin
                            state <= CTRL_LOCAL;
                            done  <= 1'b1;
                        end else begin
                            state <= CTRL_WAIT_UNIT;
                        end
                    end
                end
                CTRL_LOCAL: state <= CTRL_IDLE;
                CTRL_WAIT_UNIT: begin
                    // Stay busy through our own done cycle
                    if (done) begin
                        state <= CTRL_IDLE;
                    end else if (unit_done) begin
                        done <= 1'b1;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // Result register
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= dec_op;
            rsp.out  <= local_out;
            rsp.flag <= 2'b00;
        end else if ((state == CTRL_WAIT_UNIT) && unit_done) begin
            case (op_q)
                OP_ITOF: rsp <= '{out: itof_result, flag: 2'b00};
                OP_FTOI: rsp <= '{out: ftoi_result, flag: 2'b00};
                default: rsp <= '{out: arith_result, flag: arith_flag};
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_arith_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_arith_unit
    import integer_alu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  arith_op_e         op,
    input  logic [WORD_W-1:0] a,
    input  logic [WORD_W-1:0] b,
    output logic [WORD_W-1:0] result,
    output logic [1:0]        flag,
    output logic              done
);

    localparam int CNT_W = $clog2(WORD_W);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(WORD_W - 1);

    arith_state_e        state;
    arith_op_e           op_q;
    logic                sign_q;
    logic [CNT_W-1:0]    count;
    logic [WORD_W-1:0]   opnd;
    logic [WORD_W-1:0]   hi;
    logic [WORD_W-1:0]   lo;

    logic [WORD_W-1:0]   a_mag;
    logic [WORD_W-1:0]   b_mag;
    logic [WORD_W-1:0]   sum;
    logic [WORD_W-1:0]   diff;
    logic                add_ovf;
    logic                sub_ovf;
    logic [WORD_W:0]     mul_sum;
    logic [WORD_W:0]     div_shift;
    logic [WORD_W+1:0]   div_diff;
    logic [WORD_W-1:0]   hi_nx;
    logic [WORD_W-1:0]   lo_nx;
    logic [2*WORD_W-1:0] prod_s;
    logic [WORD_W-1:0]   quo_s;
    logic                mul_ovf;
    logic                div_ovf;

    assign done = (state == ARITH_FINISH);

    //////////////////////////////////////////////////
    // Single step add and sub
    assign sum     = a + b;
    assign diff    = a - b;
    assign add_ovf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
    assign sub_ovf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

    // INT_MIN maps to 2^31 as unsigned
    assign a_mag = a[WORD_W-1] ? -a : a;
    assign b_mag = b[WORD_W-1] ? -b : b;

    //////////////////////////////////////////////////
    // One iteration
    // Mul: hi:lo is the product, lo starts as the multiplier
    // Div: hi is the remainder, lo shifts dividend out and quotient in
    assign mul_sum   = {1'b0, hi} + (lo[0] ? {1'b0, opnd} : '0);
    assign div_shift = {hi, lo[WORD_W-1]};
    assign div_diff  = {1'b0, div_shift} - {2'b00, opnd};

    always_comb begin
        if (op_q == ARITH_MUL) begin
            hi_nx = mul_sum[WORD_W:1];
            lo_nx = {mul_sum[0], lo[WORD_W-1:1]};
        end else if (!div_diff[WORD_W+1]) begin
            hi_nx = div_diff[WORD_W-1:0];
            lo_nx = {lo[WORD_W-2:0], 1'b1};
        end else begin
            hi_nx = div_shift[WORD_W-1:0];
            lo_nx = {lo[WORD_W-2:0], 1'b0};
        end
    end

    // Sign correction on the last step
    assign prod_s  = sign_q ? -{hi_nx, lo_nx} : {hi_nx, lo_nx};
    assign mul_ovf = !((&prod_s[2*WORD_W-1:WORD_W-1]) || !(|prod_s[2*WORD_W-1:WORD_W-1]));
    assign quo_s   = sign_q ? -lo_nx : lo_nx;
    // Positive quotient of 2^31 only comes from INT_MIN / -1
    assign div_ovf = lo_nx[WORD_W-1] && !sign_q;

    //////////////////////////////////////////////////
    // FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARITH_IDLE;
            count <= '0;
        end else begin
            case (state)
                ARITH_IDLE: begin
                    if (start) begin
                        count <= '0;
                        if ((op == ARITH_ADD) || (op == ARITH_SUB)) begin
                            state <= ARITH_FINISH;
                        end else begin
                            state <= ARITH_ITER;
                        end
                    end
                end
                ARITH_ITER: begin
                    if (count == LAST_STEP) begin
                        state <= ARITH_FINISH;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                ARITH_FINISH: state <= ARITH_IDLE;
                default:      state <= ARITH_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start && (state == ARITH_IDLE)) begin
            op_q   <= op;
            sign_q <= a[WORD_W-1] ^ b[WORD_W-1];
            hi     <= '0;
            if (op == ARITH_MUL) begin
                opnd <= a_mag;
                lo   <= b_mag;
            end else begin
                opnd <= b_mag;
                lo   <= a_mag;
            end
            if (op == ARITH_ADD) begin
                result <= sum;
                flag   <= {add_ovf, sum == '0};
            end else if (op == ARITH_SUB) begin
                result <= diff;
                flag   <= {sub_ovf, diff == '0};
            end
        end else if (state == ARITH_ITER) begin
            hi <= hi_nx;
            lo <= lo_nx;
            if (count == LAST_STEP) begin
                if (op_q == ARITH_MUL) begin
                    result <= prod_s[WORD_W-1:0];
                    flag   <= {mul_ovf, prod_s[WORD_W-1:0] == '0};
                end else if (opnd == '0) begin
                    // Divide by zero
                    result <= '0;
                    flag   <= 2'b11;
                end else begin
                    result <= quo_s;
                    flag   <= {div_ovf, quo_s == '0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_to_float.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_to_float
    import integer_alu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [WORD_W-1:0] in,
    output logic [WORD_W-1:0] result,
    output logic              done
);

    // Exponent when the leading one sits in the top bit
    localparam logic [FP_EXP_W-1:0] EXP_TOP = FP_EXP_W'(FP_BIAS + WORD_W - 1);

    logic                running;
    logic                sign_q;
    logic [FP_EXP_W-1:0] exp_q;
    logic [WORD_W-1:0]   mag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= (in != '0);
                done    <= (in == '0);
            end else if (running && mag[WORD_W-1]) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Normalize one bit per cycle, then pack
    always_ff @(posedge clk) begin
        if (start) begin
            sign_q <= in[WORD_W-1];
            mag    <= in[WORD_W-1] ? -in : in;
            exp_q  <= EXP_TOP;
            if (in == '0) begin
                result <= '0;
            end
        end else if (running) begin
            if (mag[WORD_W-1]) begin
                // Hidden bit dropped, low bits truncated
                result <= {sign_q, exp_q, mag[WORD_W-2 -: FP_MAN_W]};
            end else begin
                mag   <= mag << 1;
                exp_q <= exp_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/float_to_int.sv ====
`timescale 1ns/1ns
`default_nettype none

module float_to_int
    import integer_alu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [WORD_W-1:0] in,
    output logic [WORD_W-1:0] result,
    output logic              done
);

    localparam int CNT_W = $clog2(WORD_W);
    // First exponent that no longer fits a signed word
    localparam logic [FP_EXP_W-1:0] EXP_SAT = FP_EXP_W'(FP_BIAS + WORD_W - 1);
    localparam logic [WORD_W-1:0]   INT_MAX = {1'b0, {(WORD_W-1){1'b1}}};
    localparam logic [WORD_W-1:0]   INT_MIN = {1'b1, {(WORD_W-1){1'b0}}};

    logic                sgn;
    logic [FP_EXP_W-1:0] exp_in;
    logic [FP_MAN_W-1:0] man_in;
    logic                in_range;
    logic [FP_EXP_W-1:0] sh_full;

    logic                running;
    logic                sign_q;
    logic [CNT_W-1:0]    sh_q;
    logic [WORD_W-1:0]   mag;

    assign {sgn, exp_in, man_in} = in;
    assign in_range = (exp_in >= FP_EXP_W'(FP_BIAS)) && (exp_in < EXP_SAT);
    // Right shifts needed to bring the binary point to bit 0
    assign sh_full  = EXP_SAT - exp_in;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= in_range;
                done    <= !in_range;
            end else if (running && (sh_q == '0)) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Denormalize one bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            sign_q <= sgn;
            sh_q   <= sh_full[CNT_W-1:0];
            mag    <= {1'b1, man_in, {(WORD_W-1-FP_MAN_W){1'b0}}};
            if (exp_in < FP_EXP_W'(FP_BIAS)) begin
                result <= '0;
            end else if (!in_range) begin
                // Also covers NaN, infinity and exactly -2^31
                result <= sgn ? INT_MIN : INT_MAX;
            end
        end else if (running) begin
            if (sh_q == '0) begin
                result <= sign_q ? -mag : mag;
            end else begin
                mag  <= mag >> 1;
                sh_q <= sh_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/integer_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module integer_alu
    import integer_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  alu_req_t req,
    output alu_rsp_t rsp,
    output logic     done,
    output logic     busy
);

    logic              arith_start;
    arith_op_e         arith_op;
    logic [WORD_W-1:0] arith_a;
    logic [WORD_W-1:0] arith_b;
    logic [WORD_W-1:0] arith_result;
    logic [1:0]        arith_flag;
    logic              arith_done;
    logic              itof_start;
    logic [WORD_W-1:0] itof_result;
    logic              itof_done;
    logic              ftoi_start;
    logic [WORD_W-1:0] ftoi_result;
    logic              ftoi_done;
    logic [WORD_W-1:0] cvt_in;

    alu_ctrl ctrl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .req          (req),
        .rsp          (rsp),
        .done         (done),
        .busy         (busy),
        .arith_start  (arith_start),
        .arith_op     (arith_op),
        .arith_a      (arith_a),
        .arith_b      (arith_b),
        .arith_result (arith_result),
        .arith_flag   (arith_flag),
        .arith_done   (arith_done),
        .itof_start   (itof_start),
        .itof_result  (itof_result),
        .itof_done    (itof_done),
        .ftoi_start   (ftoi_start),
        .ftoi_result  (ftoi_result),
        .ftoi_done    (ftoi_done),
        .cvt_in       (cvt_in)
    );

    int_arith_unit arith0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (arith_start),
        .op     (arith_op),
        .a      (arith_a),
        .b      (arith_b),
        .result (arith_result),
        .flag   (arith_flag),
        .done   (arith_done)
    );

    // Both converters read op1
    int_to_float itof0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (itof_start),
        .in     (cvt_in),
        .result (itof_result),
        .done   (itof_done)
    );

    float_to_int ftoi0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (ftoi_start),
        .in     (cvt_in),
        .result (ftoi_result),
        .done   (ftoi_done)
    );

endmodule

`default_nettype wire

// ==== verif/integer_alu_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module integer_alu_sva
    import integer_alu_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input ctrl_state_e state,
    input alu_op_e     op_q,
    input alu_rsp_t    rsp,
    input logic        done,
    input logic        busy,
    input logic        arith_start,
    input logic        itof_start,
    input logic        ftoi_start
);

    // Done is a one cycle strobe
    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done high in two consecutive cycles");

    done_in_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else $error("done seen while not busy");

    // A unit start hands the controller over to WAIT_UNIT
    start_to_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (arith_start || itof_start || ftoi_start) |=> (state == CTRL_WAIT_UNIT))
        else $error("unit start not followed by WAIT_UNIT");

    // Only the arithmetic group reports flags
    flag_clear: assert property (@(posedge clk) disable iff (!rst_n)
        (done && (op_q[3:2] != 2'b00)) |-> (rsp.flag == 2'b00))
        else $error("nonzero flag on a non-arithmetic result");

endmodule

bind alu_ctrl integer_alu_sva sva0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .op_q        (op_q),
    .rsp         (rsp),
    .done        (done),
    .busy        (busy),
    .arith_start (arith_start),
    .itof_start  (itof_start),
    .ftoi_start  (ftoi_start)
);

`default_nettype wire

// ==== verif/integer_alu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module integer_alu_tb
    import integer_alu_pkg::*;
();

    localparam int     DONE_TIMEOUT = 200;
    localparam longint S32_MAX      = 64'sd2147483647;
    localparam longint S32_MIN      = -64'sd2147483648;

    logic     clk;
    logic     rst_n;
    logic     en;
    alu_req_t req;
    alu_rsp_t rsp;
    logic     done;
    logic     busy;
    int       checks;
    int       errors;

    alu_op_e local_ops[6] = '{OP_NOT, OP_AND, OP_OR, OP_XOR, OP_WRITE_HIGH, OP_WRITE_LOW};
    logic [31:0] edge_vals[5] = '{32'h7fff_ffff, 32'h8000_0000, 32'h0, 32'hffff_ffff, 32'h1};

    integer_alu dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .req   (req),
        .rsp   (rsp),
        .done  (done),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    function automatic logic [31:0] itof_model(input logic [31:0] v);
        logic [31:0] mag;
        logic [31:0] norm;
        int          lead;
        int          i;
        mag  = v[31] ? -v : v;
        lead = 0;
        for (i = 0; i < 32; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        // Leading one to bit 31, keep the 23 bits below it
        norm = mag << (31 - lead);
        if (v == 32'd0) begin
            return 32'd0;
        end
        return {v[31], 8'(127 + lead), norm[30:8]};
    endfunction

    function automatic logic [31:0] ftoi_model(input logic [31:0] f);
        int     e;
        longint m;
        longint val;
        e = int'(f[30:23]) - 127;
        if (e < 0) begin
            return 32'd0;
        end
        if (e >= 31) begin
            return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        m = longint'({1'b1, f[22:0]});
        if (e >= 23) begin
            val = m << (e - 23);
        end else begin
            val = m >> (23 - e);
        end
        if (f[31]) begin
            val = -val;
        end
        return val[31:0];
    endfunction

    function automatic alu_rsp_t model(input alu_req_t r);
        alu_rsp_t m;
        longint   a_s;
        longint   b_s;
        longint   wide;
        logic     ovf;
        a_s    = longint'($signed(r.op1));
        b_s    = longint'($signed(r.op2));
        wide   = 0;
        ovf    = 1'b0;
        m.out  = '0;
        m.flag = 2'b00;
        case (r.opcode)
            OP_ADD: wide = a_s + b_s;
            OP_SUB: wide = a_s - b_s;
            OP_MUL: wide = a_s * b_s;
            OP_DIV: begin
                if (b_s != 0) begin
                    wide = a_s / b_s;
                end else begin
                    ovf = 1'b1;
                end
            end
            OP_NOT:        m.out = ~r.op1;
            OP_AND:        m.out = r.op1 & r.op2;
            OP_OR:         m.out = r.op1 | r.op2;
            OP_XOR:        m.out = r.op1 ^ r.op2;
            OP_WRITE_HIGH: m.out = {r.op2[15:0], r.op1[15:0]};
            OP_WRITE_LOW:  m.out = {r.op1[31:16], r.op2[15:0]};
            OP_ITOF:       m.out = itof_model(r.op1);
            OP_FTOI:       m.out = ftoi_model(r.op1);
            default:       m.out = '0;
        endcase
        if (r.opcode inside {OP_ADD, OP_SUB, OP_MUL, OP_DIV}) begin
            m.out  = wide[31:0];
            ovf    = ovf || (wide > S32_MAX) || (wide < S32_MIN);
            m.flag = {ovf, m.out == 32'd0};
        end
        return m;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and checking
    function automatic alu_req_t make_req(alu_op_e op, logic [31:0] a, logic [31:0] b);
        alu_req_t r;
        r.opcode = op;
        r.op1    = a;
        r.op2    = b;
        return r;
    endfunction

    // Signed value with a random magnitude range
    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        v = $urandom >> $urandom_range(31, 0);
        if ($urandom_range(1, 0) != 0) begin
            v = -v;
        end
        return v;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic send_request(input alu_req_t r);
        @(posedge clk);
        en  <= 1'b1;
        req <= r;
        @(posedge clk);
        en  <= 1'b0;
    endtask

    // Counts falling edges from the accepting edge until done
    task automatic wait_for_done(output int cycles, output bit seen);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && (cycles < DONE_TIMEOUT));
        seen = done;
        if (!seen) begin
            errors++;
            $display("timeout: no done within %0d cycles at time %0t", DONE_TIMEOUT, $time);
        end
    endtask

    task automatic run_and_check(input alu_req_t r, input int want_latency);
        alu_rsp_t exp_rsp;
        int       cycles;
        bit       seen;
        exp_rsp = model(r);
        send_request(r);
        wait_for_done(cycles, seen);
        if (seen) begin
            check_value("rsp.out", exp_rsp.out, rsp.out);
            check_value("rsp.flag", 32'(exp_rsp.flag), 32'(rsp.flag));
            check_value("busy", 32'd1, 32'(busy));
            if (want_latency > 0) begin
                check_value("done_latency", 32'(want_latency), 32'(cycles));
            end
            // Busy ends with the done cycle
            @(negedge clk);
            check_value("busy", 32'd0, 32'(busy));
        end
    endtask

    task automatic report_test(string name, int ops, int mark);
        $display("test %-14s %0d ops, %0d errors", name, ops, errors - mark);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        alu_req_t r1;
        alu_rsp_t exp_rsp;
        int       cycles;
        bit       seen;
        int       extra;
        int       mark;
        int       n;
        int       i;
        int       j;
        checks = 0;
        errors = 0;
        rst_n  = 1'b0;
        en     = 1'b0;
        req    = '0;
        void'($urandom(15600));
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Reset state, then logic and halfword ops
        mark = errors;
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        for (n = 0; n < 60; n++) begin
            run_and_check(make_req(local_ops[$urandom_range(5, 0)], $urandom, $urandom), 1);
        end
        report_test("reset_local", 60, mark);

        mark = errors;
        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 5; j++) begin
                run_and_check(make_req(OP_ADD, edge_vals[i], edge_vals[j]), 0);
                run_and_check(make_req(OP_SUB, edge_vals[i], edge_vals[j]), 0);
            end
        end
        for (n = 0; n < 40; n++) begin
            r1 = make_req($urandom_range(1, 0) != 0 ? OP_SUB : OP_ADD, $urandom, $urandom);
            run_and_check(r1, 0);
        end
        report_test("add_sub", 90, mark);

        mark = errors;
        run_and_check(make_req(OP_DIV, 32'd12345, 32'd0), 0);
        run_and_check(make_req(OP_DIV, 32'h8000_0000, 32'hffff_ffff), 0);
        run_and_check(make_req(OP_DIV, 32'h8000_0000, 32'd1), 0);
        run_and_check(make_req(OP_MUL, 32'h8000_0000, 32'h8000_0000), 0);
        run_and_check(make_req(OP_MUL, 32'h8000_0000, 32'hffff_ffff), 0);
        for (n = 0; n < 50; n++) begin
            r1 = make_req(n % 2 != 0 ? OP_DIV : OP_MUL, rand_word(), rand_word());
            run_and_check(r1, 0);
        end
        report_test("mul_div", 55, mark);

        mark = errors;
        run_and_check(make_req(OP_ITOF, 32'd0, $urandom), 0);
        run_and_check(make_req(OP_ITOF, 32'h8000_0000, $urandom), 0);
        run_and_check(make_req(OP_ITOF, 32'h7fff_ffff, $urandom), 0);
        run_and_check(make_req(OP_ITOF, 32'hffff_ffff, $urandom), 0);
        for (n = 0; n < 40; n++) begin
            run_and_check(make_req(OP_ITOF, rand_word(), $urandom), 0);
        end
        report_test("itof", 44, mark);

        // NaN, infinity, +-2^31, just below 1.0, zero
        mark = errors;
        run_and_check(make_req(OP_FTOI, 32'h7fc0_0000, 32'd0), 0);
        run_and_check(make_req(OP_FTOI, 32'hff80_0000, 32'd0), 0);
        run_and_check(make_req(OP_FTOI, 32'hcf00_0000, 32'd0), 0);
        run_and_check(make_req(OP_FTOI, 32'h4f00_0000, 32'd0), 0);
        run_and_check(make_req(OP_FTOI, 32'h3f7f_ffff, 32'd0), 0);
        run_and_check(make_req(OP_FTOI, 32'h0000_0000, 32'd0), 0);
        for (n = 0; n < 60; n++) begin
            r1 = make_req(OP_FTOI, {1'($urandom_range(1, 0)), 8'($urandom_range(165, 110)),
                                    23'($urandom)}, 32'd0);
            run_and_check(r1, 0);
        end
        report_test("ftoi", 66, mark);

        // A second en while busy must not start anything
        mark = errors;
        for (n = 0; n < 6; n++) begin
            r1      = make_req(n % 2 != 0 ? OP_DIV : OP_MUL, rand_word(), rand_word());
            exp_rsp = model(r1);
            send_request(r1);
            @(posedge clk);
            en  <= 1'b1;
            req <= make_req(OP_XOR, $urandom, $urandom);
            @(posedge clk);
            en  <= 1'b0;
            wait_for_done(cycles, seen);
            if (seen) begin
                check_value("rsp.out", exp_rsp.out, rsp.out);
                check_value("rsp.flag", 32'(exp_rsp.flag), 32'(rsp.flag));
                extra = 0;
                repeat (40) begin
                    @(negedge clk);
                    if (done) begin
                        extra++;
                    end
                end
                check_value("extra_done_count", 32'd0, 32'(extra));
            end
        end
        report_test("back_pressure", 6, mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== integer_alu.f ====
hw/integer_alu_pkg.sv
hw/alu_ctrl.sv
hw/int_arith_unit.sv
hw/int_to_float.sv
hw/float_to_int.sv
hw/integer_alu.sv
verif/integer_alu_sva.sv
verif/integer_alu_tb.sv

// ==== Makefile ====
SRCS := $(shell cat integer_alu.f)

.PHONY: run clean

run: obj_dir/Vinteger_alu_tb
	./obj_dir/Vinteger_alu_tb > sim.log 2>&1 || echo "Test failed" >> sim.log
	cat sim.log
	! grep -q "Test failed" sim.log

obj_dir/Vinteger_alu_tb: integer_alu.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module integer_alu_tb -f integer_alu.f

clean:
	rm -rf obj_dir sim.log
